/* src/cpu_pkg.sv */
package cpu_pkg;

  localparam int unsigned DATA_WIDTH = 8;
  localparam int unsigned ADDR_WIDTH = 16;
  localparam int unsigned DIVIDER_WIDTH = 8;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  typedef enum logic [7:0] {
    OP_NOP     = 8'hEA,
    OP_LDA_IMM = 8'hA9,
    OP_LDA_ZP  = 8'hA5,
    OP_ADC_IMM = 8'h69,
    OP_STA_ZP  = 8'h85,
    OP_JMP_ABS = 8'h4C
  } opcode_e;

  typedef enum logic [2:0] {
    STAGE_FETCH,
    STAGE_OPERAND,
    STAGE_EXEC,
    STAGE_WRITE_WAIT,
    STAGE_VECTOR_LOW,
    STAGE_VECTOR_HIGH
  } stage_e;

  // Source of the next bus address
  typedef enum logic [2:0] {
    ADDR_HOLD,
    ADDR_PC_NEXT,
    ADDR_ZERO_PAGE,
    ADDR_VECTOR_HIGH,
    ADDR_JUMP
  } addr_sel_e;

  typedef enum logic [1:0] {
    ACC_HOLD,
    ACC_DATA,
    ACC_SUM_HOLD
  } acc_sel_e;

  localparam addr_t RESET_VECTOR_ADDR = 16'hFFFC;
  localparam addr_t VECTOR_HIGH_ADDR = 16'hFFFD;

endpackage : cpu_pkg

/* src/cpu_ctrl_if.sv */
interface cpu_ctrl_if;
  import cpu_pkg::*;

  addr_sel_e addr_sel;
  acc_sel_e  acc_sel;
  logic      pc_increment;
  logic      pc_load_low;
  logic      pc_load_high;
  // Adder result into hold register, carry out kept pending
  logic      sum_to_hold;
  logic      commit_carry;
  logic      store_acc;

  modport sequencer(
    output addr_sel,
    output acc_sel,
    output pc_increment,
    output pc_load_low,
    output pc_load_high,
    output sum_to_hold,
    output commit_carry,
    output store_acc
  );

  modport datapath(
    input addr_sel,
    input acc_sel,
    input pc_increment,
    input pc_load_low,
    input pc_load_high,
    input sum_to_hold,
    input commit_carry,
    input store_acc
  );

endinterface : cpu_ctrl_if

/* src/cpu_clock_enable.sv */
module cpu_clock_enable #(
  parameter int unsigned CLOCK_DIVIDER = 12
) (
  input  logic clock_i,
  input  logic reset_i,
  output logic step_o
);
  import cpu_pkg::*;

  logic [DIVIDER_WIDTH-1:0] count;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count  <= '0;
      step_o <= 1'b0;
    end else if (count == DIVIDER_WIDTH'(CLOCK_DIVIDER - 1)) begin
      count  <= '0;
      step_o <= 1'b1;
    end else begin
      count  <= count + 1'b1;
      step_o <= 1'b0;
    end
  end

endmodule : cpu_clock_enable

/* src/cpu_sequencer.sv */
module cpu_sequencer (
  input  logic                clock_i,
  input  logic                reset_i,
  input  logic                step_i,
  input  cpu_pkg::data_t      data_i,
  input  logic                data_valid_i,
  output logic                bus_read_o,
  output logic                bus_write_o,
  cpu_ctrl_if.sequencer       ctrl
);
  import cpu_pkg::*;

  opcode_e opcode;
  stage_e  stage;
  stage_e  next_stage;
  logic    next_read;
  logic    next_write;
  logic    latch_opcode;
  logic    need_data;

  always_comb begin
    ctrl.addr_sel     = ADDR_HOLD;
    ctrl.acc_sel      = ACC_HOLD;
    ctrl.pc_increment = 1'b0;
    ctrl.pc_load_low  = 1'b0;
    ctrl.pc_load_high = 1'b0;
    ctrl.sum_to_hold  = 1'b0;
    ctrl.commit_carry = 1'b0;
    ctrl.store_acc    = 1'b0;
    next_stage        = stage;
    next_read         = 1'b0;
    next_write        = 1'b0;
    latch_opcode      = 1'b0;
    need_data         = 1'b0;

    case (stage)
      STAGE_FETCH: begin
        need_data         = 1'b1;
        latch_opcode      = 1'b1;
        ctrl.pc_increment = 1'b1;
        ctrl.addr_sel     = ADDR_PC_NEXT;
        next_read         = 1'b1;
        next_stage        = STAGE_OPERAND;
        // Finish a pending ADC alongside this fetch
        if (opcode == OP_ADC_IMM) begin
          ctrl.acc_sel      = ACC_SUM_HOLD;
          ctrl.commit_carry = 1'b1;
        end
      end

      STAGE_OPERAND: begin
        case (opcode)
          OP_LDA_IMM, OP_ADC_IMM: begin
            need_data         = 1'b1;
            ctrl.acc_sel      = (opcode == OP_LDA_IMM) ? ACC_DATA : ACC_HOLD;
            ctrl.sum_to_hold  = (opcode == OP_ADC_IMM);
            ctrl.pc_increment = 1'b1;
            ctrl.addr_sel     = ADDR_PC_NEXT;
            next_read         = 1'b1;
            next_stage        = STAGE_FETCH;
          end
          OP_LDA_ZP: begin
            need_data     = 1'b1;
            ctrl.addr_sel = ADDR_ZERO_PAGE;
            next_read     = 1'b1;
            next_stage    = STAGE_EXEC;
          end
          OP_STA_ZP: begin
            need_data      = 1'b1;
            ctrl.addr_sel  = ADDR_ZERO_PAGE;
            ctrl.store_acc = 1'b1;
            next_write     = 1'b1;
            next_stage     = STAGE_WRITE_WAIT;
          end
          OP_JMP_ABS: begin
            need_data        = 1'b1;
            ctrl.pc_load_low = 1'b1;
            ctrl.addr_sel    = ADDR_PC_NEXT;
            next_read        = 1'b1;
            next_stage       = STAGE_EXEC;
          end
          default: begin
            // NOP and unknown opcodes: the next opcode is already on the bus
            next_read  = 1'b1;
            next_stage = STAGE_FETCH;
          end
        endcase
      end

      STAGE_EXEC: begin
        next_read  = 1'b1;
        next_stage = STAGE_FETCH;
        if (opcode == OP_JMP_ABS) begin
          need_data         = 1'b1;
          ctrl.pc_load_high = 1'b1;
          ctrl.addr_sel     = ADDR_JUMP;
        end else begin
          need_data         = (opcode == OP_LDA_ZP);
          ctrl.acc_sel      = (opcode == OP_LDA_ZP) ? ACC_DATA : ACC_HOLD;
          ctrl.pc_increment = 1'b1;
          ctrl.addr_sel     = ADDR_PC_NEXT;
        end
      end

      STAGE_WRITE_WAIT: begin
        next_stage = STAGE_EXEC;
      end

      STAGE_VECTOR_LOW: begin
        need_data        = 1'b1;
        ctrl.pc_load_low = 1'b1;
        ctrl.addr_sel    = ADDR_VECTOR_HIGH;
        next_read        = 1'b1;
        next_stage       = STAGE_VECTOR_HIGH;
      end

      STAGE_VECTOR_HIGH: begin
        need_data         = 1'b1;
        ctrl.pc_load_high = 1'b1;
        ctrl.addr_sel     = ADDR_JUMP;
        next_read         = 1'b1;
        next_stage        = STAGE_FETCH;
      end

      default: begin
      end
    endcase

    // Stall until memory has the byte
    if (need_data && !data_valid_i) begin
      ctrl.addr_sel     = ADDR_HOLD;
      ctrl.acc_sel      = ACC_HOLD;
      ctrl.pc_increment = 1'b0;
      ctrl.pc_load_low  = 1'b0;
      ctrl.pc_load_high = 1'b0;
      ctrl.sum_to_hold  = 1'b0;
      ctrl.commit_carry = 1'b0;
      ctrl.store_acc    = 1'b0;
      next_stage        = stage;
      next_read         = bus_read_o;
      next_write        = bus_write_o;
      latch_opcode      = 1'b0;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage       <= STAGE_VECTOR_LOW;
      opcode      <= OP_NOP;
      bus_read_o  <= 1'b1;
      bus_write_o <= 1'b0;
    end else if (step_i) begin
      stage       <= next_stage;
      bus_read_o  <= next_read;
      bus_write_o <= next_write;
      if (latch_opcode) begin
        opcode <= opcode_e'(data_i);
      end
    end
  end

endmodule : cpu_sequencer

/* src/cpu_datapath.sv */
module cpu_datapath (
  input  logic           clock_i,
  input  logic           reset_i,
  input  logic           step_i,
  input  cpu_pkg::data_t data_i,
  cpu_ctrl_if.datapath   ctrl,
  output cpu_pkg::addr_t address_o,
  output cpu_pkg::data_t data_o
);
  import cpu_pkg::*;

  data_t accumulator;
  addr_t pc;
  data_t hold;
  logic  carry;
  logic  carry_pending;

  addr_t                 pc_plus_one;
  addr_t                 next_address;
  data_t                 next_accumulator;
  logic [DATA_WIDTH:0]   sum_full;

  assign pc_plus_one = pc + addr_t'(1);

  // Accumulator plus operand plus carry in
  assign sum_full = {1'b0, accumulator} + {1'b0, data_i} + {{DATA_WIDTH{1'b0}}, carry};

  always_comb begin
    case (ctrl.addr_sel)
      ADDR_PC_NEXT:     next_address = pc_plus_one;
      ADDR_ZERO_PAGE:   next_address = {8'h00, data_i};
      ADDR_VECTOR_HIGH: next_address = VECTOR_HIGH_ADDR;
      ADDR_JUMP:        next_address = {data_i, pc[7:0]};
      default:          next_address = address_o;
    endcase
  end

  always_comb begin
    case (ctrl.acc_sel)
      ACC_DATA:     next_accumulator = data_i;
      ACC_SUM_HOLD: next_accumulator = hold;
      default:      next_accumulator = accumulator;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      address_o   <= RESET_VECTOR_ADDR;
      accumulator <= '0;
      carry       <= 1'b0;
    end else if (step_i) begin
      address_o   <= next_address;
      accumulator <= next_accumulator;
      if (ctrl.commit_carry) begin
        carry <= carry_pending;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (step_i) begin
      if (ctrl.pc_increment) begin
        pc <= pc_plus_one;
      end
      if (ctrl.pc_load_low) begin
        pc[7:0] <= data_i;
      end
      if (ctrl.pc_load_high) begin
        pc[15:8] <= data_i;
      end
      if (ctrl.sum_to_hold) begin
        hold          <= sum_full[DATA_WIDTH-1:0];
        carry_pending <= sum_full[DATA_WIDTH];
      end
      if (ctrl.store_acc) begin
        data_o <= accumulator;
      end
    end
  end

endmodule : cpu_datapath

/* src/cpu_top.sv */
module cpu_top #(
  parameter int unsigned CLOCK_DIVIDER = 12
) (
  input  logic           clock_i,
  input  logic           reset_i,
  input  cpu_pkg::data_t data_i,
  input  logic           data_valid_i,
  output cpu_pkg::data_t data_o,
  output cpu_pkg::addr_t address_o,
  output logic           bus_read_o,
  output logic           bus_write_o
);

  logic step;

  cpu_ctrl_if ctrl_if_i ();

  cpu_clock_enable #(
    .CLOCK_DIVIDER(CLOCK_DIVIDER)
  ) clock_enable_i (
    .clock_i(clock_i),
    .reset_i(reset_i),
    .step_o (step)
  );

  cpu_sequencer sequencer_i (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .step_i      (step),
    .data_i      (data_i),
    .data_valid_i(data_valid_i),
    .bus_read_o  (bus_read_o),
    .bus_write_o (bus_write_o),
    .ctrl        (ctrl_if_i.sequencer)
  );

  cpu_datapath datapath_i (
    .clock_i  (clock_i),
    .reset_i  (reset_i),
    .step_i   (step),
    .data_i   (data_i),
    .ctrl     (ctrl_if_i.datapath),
    .address_o(address_o),
    .data_o   (data_o)
  );

endmodule : cpu_top

/* dv/cpu_sva.sv */
module cpu_sva (
  input logic           clock_i,
  input logic           reset_i,
  input logic           bus_read_o,
  input logic           bus_write_o,
  input cpu_pkg::addr_t address_o,
  input cpu_pkg::data_t data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  read_write_exclusive: assert property (@(posedge clock_i) disable iff (reset_i)
    !(bus_read_o && bus_write_o))
    else $error("bus_read_o and bus_write_o are high together");

  write_low_after_reset: assert property (@(posedge clock_i)
    reset_i |=> !bus_write_o)
    else $error("bus_write_o is high one cycle after reset");

  // Store address and data hold for the whole write
  store_stable: assert property (@(posedge clock_i) disable iff (reset_i)
    bus_write_o && $past(bus_write_o) |-> $stable(address_o) && $stable(data_o))
    else $error("address_o or data_o moved during a write");

endmodule : cpu_sva

bind cpu_top cpu_sva sva_i (
  .clock_i    (clock_i),
  .reset_i    (reset_i),
  .bus_read_o (bus_read_o),
  .bus_write_o(bus_write_o),
  .address_o  (address_o),
  .data_o     (data_o)
);

/* dv/tb_cpu.sv */
module tb_cpu;
  timeunit 1ns;
  timeprecision 1ps;

  import cpu_pkg::*;

  localparam int unsigned CLOCK_DIVIDER = 4;
  localparam int NUM_ROWS = 8;
  localparam int JUMP_ROW = 4;
  localparam int JUNK_LEN = 6;
  localparam addr_t PROGRAM_BASE = 16'h0300;
  localparam data_t ZP_SOURCE_BASE = 8'h80;
  // Rows x 20 steps x divider x 10 ns, four times over for stalls
  localparam int WATCHDOG_NS = NUM_ROWS * 20 * CLOCK_DIVIDER * 10 * 4;

  typedef struct packed {
    data_t lda_value;
    data_t adc_value;
    data_t store_addr;
    logic  from_zero_page;
    logic  with_nop;
  } row_t;

  // LDA byte, ADC byte, STA address, LDA from zero page, NOP inserted
  row_t rows [NUM_ROWS] = '{
    '{8'h12, 8'h34, 8'h10, 1'b0, 1'b0},
    '{8'hF0, 8'h20, 8'h11, 1'b0, 1'b1},
    '{8'h05, 8'h06, 8'h12, 1'b1, 1'b0},
    '{8'h80, 8'h80, 8'h13, 1'b0, 1'b0},
    '{8'hFF, 8'h00, 8'h14, 1'b1, 1'b0},
    '{8'h7F, 8'h7F, 8'h15, 1'b0, 1'b1},
    '{8'hC3, 8'h5A, 8'h16, 1'b0, 1'b0},
    '{8'h01, 8'h01, 8'h17, 1'b1, 1'b1}
  };

  logic  clock_i = 1'b0;
  logic  reset_i;
  data_t data_i;
  logic  data_valid_i;
  data_t data_o;
  addr_t address_o;
  logic  bus_read_o;
  logic  bus_write_o;

  data_t       mem [0:65535];
  addr_t       expected_addr [NUM_ROWS];
  data_t       expected_data [NUM_ROWS];
  int          store_count = 0;
  logic [15:0] lfsr_state = 16'd52166;
  addr_t       last_address = '0;
  logic        last_write = 1'b0;
  logic        fetch_seen = 1'b0;

  always #5 clock_i = ~clock_i;

  cpu_top #(
    .CLOCK_DIVIDER(CLOCK_DIVIDER)
  ) cpu_top_i (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .data_i      (data_i),
    .data_valid_i(data_valid_i),
    .data_o      (data_o),
    .address_o   (address_o),
    .bus_read_o  (bus_read_o),
    .bus_write_o (bus_write_o)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic record_store();
    if (store_count >= NUM_ROWS) begin
      $display("A store to address %h came after the last table row", address_o);
      $display("Simulation FAILED");
      $fatal(1, "unexpected store");
    end else begin
      check_value(address_o, expected_addr[store_count], "store address");
      check_value(16'(data_o), 16'(expected_data[store_count]), "store data");
      mem[address_o] = data_o;
      store_count++;
    end
  endtask

  task automatic put_byte(inout addr_t loc, input data_t value);
    mem[loc] = value;
    loc = loc + 16'd1;
  endtask

  task automatic build_program();
    addr_t loc;
    addr_t target;
    data_t source;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = 8'(a >> 8) ^ 8'(a) ^ 8'h3C;
    end
    mem[RESET_VECTOR_ADDR] = PROGRAM_BASE[7:0];
    mem[VECTOR_HIGH_ADDR] = PROGRAM_BASE[15:8];
    loc = PROGRAM_BASE;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (r == JUMP_ROW) begin
        // Junk holds STA opcodes that would store if ever run
        target = loc + addr_t'(3 + JUNK_LEN);
        put_byte(loc, OP_JMP_ABS);
        put_byte(loc, target[7:0]);
        put_byte(loc, target[15:8]);
        for (int j = 0; j < JUNK_LEN; j++) begin
          put_byte(loc, j[0] ? data_t'(8'hE0 + j) : data_t'(OP_STA_ZP));
        end
      end
      if (rows[r].from_zero_page) begin
        source = ZP_SOURCE_BASE + data_t'(r);
        mem[{8'h00, source}] = rows[r].lda_value;
        put_byte(loc, OP_LDA_ZP);
        put_byte(loc, source);
      end else begin
        put_byte(loc, OP_LDA_IMM);
        put_byte(loc, rows[r].lda_value);
      end
      if (rows[r].with_nop) begin
        put_byte(loc, OP_NOP);
      end
      put_byte(loc, OP_ADC_IMM);
      put_byte(loc, rows[r].adc_value);
      put_byte(loc, OP_STA_ZP);
      put_byte(loc, rows[r].store_addr);
    end
    // Park the core in a jump to itself
    target = loc;
    put_byte(loc, OP_JMP_ABS);
    put_byte(loc, target[7:0]);
    put_byte(loc, target[15:8]);
  endtask

  task automatic compute_expected();
    logic [8:0] sum;
    logic       carry;
    carry = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      sum = {1'b0, rows[r].lda_value} + {1'b0, rows[r].adc_value} + {8'h00, carry};
      expected_addr[r] = {8'h00, rows[r].store_addr};
      expected_data[r] = sum[7:0];
      carry = sum[8];
    end
  endtask

  // Memory model with random but legal data_valid_i, served only on reads
  always @(posedge clock_i) begin
    data_i <= mem[address_o];
    if (!bus_read_o) begin
      data_valid_i <= 1'b0;
    end else if (address_o !== last_address || !data_valid_i) begin
      lfsr_state = lfsr_next(lfsr_state);
      data_valid_i <= lfsr_state[0];
    end
    last_address = address_o;
    if (bus_write_o && !last_write) begin
      record_store();
    end
    last_write = bus_write_o;
    if (!reset_i && !fetch_seen && address_o != RESET_VECTOR_ADDR &&
        address_o != VECTOR_HIGH_ADDR) begin
      check_value(address_o, PROGRAM_BASE, "first opcode address");
      fetch_seen = 1'b1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the program did not finish its stores within %0d ns", WATCHDOG_NS);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset_i = 1'b1;
    data_i = '0;
    data_valid_i = 1'b0;
    build_program();
    compute_expected();
    repeat (8) @(posedge clock_i);
    reset_i <= 1'b0;
    wait (store_count == NUM_ROWS);
    // Let the final jump loop run to catch stray stores
    repeat (20 * CLOCK_DIVIDER) @(posedge clock_i);
    $display("Simulation PASSED");
    $finish;
  end

endmodule : tb_cpu

/* project.f */
src/cpu_pkg.sv
src/cpu_ctrl_if.sv
src/cpu_clock_enable.sv
src/cpu_sequencer.sv
src/cpu_datapath.sv
src/cpu_top.sv
dv/cpu_sva.sv
dv/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
